// ==== design/l2_consts.svh ====
`ifndef L2_CONSTS_SVH
`define L2_CONSTS_SVH

// L1 address split. Tag and set together give the 26-bit line address
`define L1_TAG_WIDTH       20
`define L1_SET_INDEX_WIDTH 6

// Hardware threads in the core, each owning one store buffer entry
`define NUM_STRANDS 4

// Cache line geometry
`define LINE_BITS 512
`define MASK_BITS 64

// Unit ID the L2 puts on responses meant for the store path
`define STBUF_UNIT 2'd2

// L2 request opcodes used by the store path
`define PCI_STORE      3'd1
`define PCI_STORE_SYNC 3'd5

`endif

// ==== design/l2_pkg.sv ====
`include "l2_consts.svh"

package l2_pkg;

	// Data moves between L1 and L2 one full line at a time
	typedef logic [`LINE_BITS-1:0] line_data_t;

	// One enable bit per byte of the line
	typedef logic [`MASK_BITS-1:0] byte_mask_t;

	typedef logic [`L1_TAG_WIDTH-1:0] l1_tag_t;
	typedef logic [`L1_SET_INDEX_WIDTH-1:0] l1_set_t;

	// Line address as sent to L2, tag in the upper bits
	typedef logic [`L1_TAG_WIDTH+`L1_SET_INDEX_WIDTH-1:0] line_addr_t;

	typedef logic [$clog2(`NUM_STRANDS)-1:0] strand_id_t;

	// One bit per strand
	typedef logic [`NUM_STRANDS-1:0] strand_mask_t;

	typedef logic [2:0] pci_op_t;

endpackage

// ==== design/rr_arbiter.sv ====
`timescale 1ns/1ps

`include "l2_consts.svh"

module rr_arbiter
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  l2_pkg::strand_mask_t req_i,
	input  logic                 advance_i,
	output l2_pkg::strand_mask_t grant_o
);

	import l2_pkg::*;

	// Strand that currently has the highest priority
	strand_id_t prio_ptr;
	strand_id_t grant_idx;
	logic       grant_any;

	// Walk the requesters starting at the pointer and take the first one found
	always_comb
	begin : pick
		strand_id_t idx;

		grant_o = '0;
		grant_idx = prio_ptr;
		grant_any = 1'b0;
		for (int i = 0; i < `NUM_STRANDS; i++)
		begin
			idx = prio_ptr + strand_id_t'(i);
			if (!grant_any && req_i[idx])
			begin
				grant_any = 1'b1;
				grant_idx = idx;
			end
		end
		if (grant_any)
			grant_o[grant_idx] = 1'b1;
	end

	// The winner drops to lowest priority, but only once its grant is taken
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			prio_ptr <= '0;
		end
		else if (advance_i && grant_any)
		begin
			prio_ptr <= grant_idx + 1'b1;
		end
	end

endmodule

// ==== design/sync_store_tracker.sv ====
`timescale 1ns/1ps

module sync_store_tracker
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  l2_pkg::strand_mask_t sync_req_i,
	input  l2_pkg::strand_mask_t l2_ack_i,
	input  l2_pkg::strand_id_t   ack_strand_i,
	input  logic                 status_i,
	input  l2_pkg::strand_id_t   query_strand_i,
	output logic                 need_rollback_o,
	output l2_pkg::strand_mask_t wait_o,
	output logic                 result_o
);

	import l2_pkg::*;

	// A strand is waiting between its first synchronized store and the L2 answer.
	// It is completed from that answer until it retries the store
	strand_mask_t waiting;
	strand_mask_t completed;
	strand_mask_t result_q;
	strand_mask_t ack_waiting;

	assign ack_waiting = waiting & l2_ack_i;

	// Only a strand without a stored answer has to go around again
	assign need_rollback_o = |(sync_req_i & ~completed);

	assign wait_o = waiting;

	// Status bit that the retried store hands back to the strand
	assign result_o = result_q[query_strand_i];

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			waiting <= '0;
			completed <= '0;
			result_q <= '0;
		end
		else
		begin
			waiting <= (waiting | (sync_req_i & ~completed)) & ~l2_ack_i;

			// The retry consumes the answer, so the store after it rolls back again
			completed <= (completed | ack_waiting) & ~sync_req_i;

			if (|ack_waiting)
			begin
				result_q[ack_strand_i] <= status_i;
			end
		end
	end

endmodule

// ==== design/store_buffer.sv ====
`timescale 1ns/1ps

`include "l2_consts.svh"

module store_buffer
(
	input  logic                 clk,
	input  logic                 rst_n_i,

	input  logic                 write_i,
	input  logic                 synchronized_i,
	input  l2_pkg::strand_id_t   strand_i,
	input  l2_pkg::l1_tag_t      tag_i,
	input  l2_pkg::l1_set_t      set_i,
	input  l2_pkg::line_data_t   data_i,
	input  l2_pkg::byte_mask_t   mask_i,

	output l2_pkg::line_data_t   data_o,
	output l2_pkg::byte_mask_t   mask_o,
	output logic                 rollback_o,
	output l2_pkg::strand_mask_t resume_strands_o,
	output logic                 store_update_o,
	output l2_pkg::l1_set_t      store_update_set_o,

	output logic                 l2_req_valid_o,
	output l2_pkg::pci_op_t      l2_req_op_o,
	output l2_pkg::strand_id_t   l2_req_strand_o,
	output l2_pkg::line_addr_t   l2_req_addr_o,
	output l2_pkg::line_data_t   l2_req_data_o,
	output l2_pkg::byte_mask_t   l2_req_mask_o,
	input  logic                 l2_req_ack_i,

	input  logic                 l2_resp_valid_i,
	input  logic                 l2_resp_status_i,
	input  logic [1:0]           l2_resp_unit_i,
	input  l2_pkg::strand_id_t   l2_resp_strand_i,
	input  logic                 l2_resp_update_i,

	output l2_pkg::strand_mask_t arb_req_o,
	output logic                 arb_advance_o,
	input  l2_pkg::strand_mask_t arb_grant_i,

	output l2_pkg::strand_mask_t sync_req_o,
	output l2_pkg::strand_mask_t l2_ack_o,
	input  logic                 need_sync_rollback_i,
	input  l2_pkg::strand_mask_t sync_wait_i,
	input  logic                 sync_result_i
);

	import l2_pkg::*;

	localparam int WORDS = `LINE_BITS / 32;

	// One entry per strand
	strand_mask_t entry_valid;
	strand_mask_t entry_acked;
	logic         entry_sync [`NUM_STRANDS];
	l1_tag_t      entry_tag [`NUM_STRANDS];
	l1_set_t      entry_set [`NUM_STRANDS];
	line_data_t   entry_data [`NUM_STRANDS];
	byte_mask_t   entry_mask [`NUM_STRANDS];

	// Issue state. At most one request is outstanding towards L2
	logic         issue_pending;
	strand_id_t   issue_entry;
	strand_id_t   grant_idx;

	// Strands parked because their entry was occupied
	strand_mask_t store_wait;
	logic         full_q;
	logic         sync_rollback_q;

	strand_mask_t strand_bit;
	strand_mask_t finish_mask;
	logic         resp_hit;
	logic         store_complete;
	logic         collision;
	logic         full;
	logic         enqueue;

	assign strand_bit = strand_mask_t'(1) << strand_i;

	assign resp_hit = l2_resp_valid_i && (l2_resp_unit_i == `STBUF_UNIT);
	assign finish_mask = resp_hit ? (strand_mask_t'(1) << l2_resp_strand_i) : '0;
	assign store_complete = resp_hit && entry_valid[l2_resp_strand_i];

	// A store arriving in the same cycle its strand's entry retires may take the entry over
	assign collision = store_complete && write_i && (strand_i == l2_resp_strand_i);

	assign full = write_i && entry_valid[strand_i] && !collision;

	// A synchronized store is queued only on the attempt that rolls back.
	// The retry just picks up the L2 status
	assign enqueue = write_i && (!entry_valid[strand_i] || collision)
		&& (!synchronized_i || need_sync_rollback_i);

	assign sync_req_o = (write_i && synchronized_i && !entry_valid[strand_i]) ? strand_bit : '0;
	assign l2_ack_o = finish_mask;

	assign arb_req_o = entry_valid & ~entry_acked;
	assign arb_advance_o = !issue_pending;

	always_comb
	begin
		grant_idx = '0;
		for (int i = `NUM_STRANDS - 1; i >= 0; i--)
		begin
			if (arb_grant_i[i])
				grant_idx = strand_id_t'(i);
		end
	end

	assign l2_req_valid_o = issue_pending;
	assign l2_req_op_o = entry_sync[issue_entry] ? `PCI_STORE_SYNC : `PCI_STORE;
	assign l2_req_strand_o = issue_entry;
	assign l2_req_addr_o = {entry_tag[issue_entry], entry_set[issue_entry]};
	assign l2_req_data_o = entry_data[issue_entry];
	assign l2_req_mask_o = entry_mask[issue_entry];

	assign store_update_o = resp_hit && l2_resp_update_i;
	assign store_update_set_o = resp_hit ? entry_set[l2_resp_strand_i] : '0;

	assign rollback_o = full_q || sync_rollback_q;

	// Only the same strand sees its own pending store
	always_ff @(posedge clk)
	begin
		if (write_i && synchronized_i)
		begin
			mask_o <= '1;
			data_o <= {WORDS{31'd0, sync_result_i}};
		end
		else if (entry_valid[strand_i] && entry_tag[strand_i] == tag_i
			&& entry_set[strand_i] == set_i)
		begin
			mask_o <= entry_mask[strand_i];
			data_o <= entry_data[strand_i];
		end
		else
		begin
			mask_o <= '0;
			data_o <= '0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (enqueue)
		begin
			entry_tag[strand_i] <= tag_i;
			entry_set[strand_i] <= set_i;
			entry_data[strand_i] <= data_i;
			entry_mask[strand_i] <= mask_i;
			entry_sync[strand_i] <= synchronized_i;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			entry_valid <= '0;
			entry_acked <= '0;
			issue_pending <= 1'b0;
			issue_entry <= '0;
		end
		else
		begin
			if (enqueue)
				entry_valid[strand_i] <= 1'b1;

			// A fresh grant is taken only once the previous ack has cleared
			if (issue_pending)
			begin
				if (l2_req_ack_i)
				begin
					entry_acked[issue_entry] <= 1'b1;
					issue_pending <= 1'b0;
				end
			end
			else if (|arb_grant_i)
			begin
				issue_entry <= grant_idx;
				issue_pending <= 1'b1;
			end

			// The response retires the entry. A replacing store keeps it valid and re-issues
			if (store_complete)
			begin
				if (!collision)
					entry_valid[l2_resp_strand_i] <= 1'b0;
				entry_acked[l2_resp_strand_i] <= 1'b0;
			end
		end
	end

	// Resume comes a cycle late so the strand has already been suspended
	always_ff @(posedge clk)
	begin
		if (!rst_n_i)
		begin
			store_wait <= '0;
			full_q <= 1'b0;
			sync_rollback_q <= 1'b0;
			resume_strands_o <= '0;
		end
		else
		begin
			store_wait <= (store_wait & ~finish_mask) | (full ? strand_bit : '0);
			full_q <= full;
			sync_rollback_q <= need_sync_rollback_i;
			resume_strands_o <= (finish_mask & store_wait) | (finish_mask & sync_wait_i);
		end
	end

endmodule

// ==== design/store_path_top.sv ====
`timescale 1ns/1ps

module store_path_top
(
	input  logic                 clk,
	input  logic                 rst_n_i,

	input  logic                 write_i,
	input  logic                 synchronized_i,
	input  l2_pkg::strand_id_t   strand_i,
	input  l2_pkg::l1_tag_t      tag_i,
	input  l2_pkg::l1_set_t      set_i,
	input  l2_pkg::line_data_t   data_i,
	input  l2_pkg::byte_mask_t   mask_i,

	output l2_pkg::line_data_t   data_o,
	output l2_pkg::byte_mask_t   mask_o,
	output logic                 rollback_o,
	output l2_pkg::strand_mask_t resume_strands_o,
	output logic                 store_update_o,
	output l2_pkg::l1_set_t      store_update_set_o,

	output logic                 l2_req_valid_o,
	output l2_pkg::pci_op_t      l2_req_op_o,
	output l2_pkg::strand_id_t   l2_req_strand_o,
	output l2_pkg::line_addr_t   l2_req_addr_o,
	output l2_pkg::line_data_t   l2_req_data_o,
	output l2_pkg::byte_mask_t   l2_req_mask_o,
	input  logic                 l2_req_ack_i,

	input  logic                 l2_resp_valid_i,
	input  logic                 l2_resp_status_i,
	input  logic [1:0]           l2_resp_unit_i,
	input  l2_pkg::strand_id_t   l2_resp_strand_i,
	input  logic                 l2_resp_update_i
);

	import l2_pkg::*;

	strand_mask_t arb_req;
	strand_mask_t arb_grant;
	logic         arb_advance;
	strand_mask_t sync_req;
	strand_mask_t l2_ack;
	strand_mask_t sync_wait;
	logic         need_sync_rollback;
	logic         sync_result;

	store_buffer u_store_buffer
	(
		.clk                  (clk),
		.rst_n_i              (rst_n_i),
		.write_i              (write_i),
		.synchronized_i       (synchronized_i),
		.strand_i             (strand_i),
		.tag_i                (tag_i),
		.set_i                (set_i),
		.data_i               (data_i),
		.mask_i               (mask_i),
		.data_o               (data_o),
		.mask_o               (mask_o),
		.rollback_o           (rollback_o),
		.resume_strands_o     (resume_strands_o),
		.store_update_o       (store_update_o),
		.store_update_set_o   (store_update_set_o),
		.l2_req_valid_o       (l2_req_valid_o),
		.l2_req_op_o          (l2_req_op_o),
		.l2_req_strand_o      (l2_req_strand_o),
		.l2_req_addr_o        (l2_req_addr_o),
		.l2_req_data_o        (l2_req_data_o),
		.l2_req_mask_o        (l2_req_mask_o),
		.l2_req_ack_i         (l2_req_ack_i),
		.l2_resp_valid_i      (l2_resp_valid_i),
		.l2_resp_status_i     (l2_resp_status_i),
		.l2_resp_unit_i       (l2_resp_unit_i),
		.l2_resp_strand_i     (l2_resp_strand_i),
		.l2_resp_update_i     (l2_resp_update_i),
		.arb_req_o            (arb_req),
		.arb_advance_o        (arb_advance),
		.arb_grant_i          (arb_grant),
		.sync_req_o           (sync_req),
		.l2_ack_o             (l2_ack),
		.need_sync_rollback_i (need_sync_rollback),
		.sync_wait_i          (sync_wait),
		.sync_result_i        (sync_result)
	);

	rr_arbiter u_rr_arbiter
	(
		.clk       (clk),
		.rst_n_i   (rst_n_i),
		.req_i     (arb_req),
		.advance_i (arb_advance),
		.grant_o   (arb_grant)
	);

	// The tracker sees the raw response strand and status, and the strand of the current access
	sync_store_tracker u_sync_store_tracker
	(
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.sync_req_i      (sync_req),
		.l2_ack_i        (l2_ack),
		.ack_strand_i    (l2_resp_strand_i),
		.status_i        (l2_resp_status_i),
		.query_strand_i  (strand_i),
		.need_rollback_o (need_sync_rollback),
		.wait_o          (sync_wait),
		.result_o        (sync_result)
	);

endmodule

// ==== testbench/tb_store_path.sv ====
`timescale 1ns/1ps

`include "l2_consts.svh"

module tb_store_path;

	import l2_pkg::*;

	// Six tests, each well under this many cycles even with the longest L2 delays
	localparam int TEST_CYCLES = 400;
	localparam int WATCHDOG_NS = (6 * TEST_CYCLES + 10) * 20;

	logic clk;
	logic rst_n_i;
	logic write_i;
	logic synchronized_i;
	strand_id_t strand_i;
	l1_tag_t tag_i;
	l1_set_t set_i;
	line_data_t data_i;
	byte_mask_t mask_i;
	line_data_t data_o;
	byte_mask_t mask_o;
	logic rollback_o;
	strand_mask_t resume_strands_o;
	logic store_update_o;
	l1_set_t store_update_set_o;
	logic l2_req_valid_o;
	pci_op_t l2_req_op_o;
	strand_id_t l2_req_strand_o;
	line_addr_t l2_req_addr_o;
	line_data_t l2_req_data_o;
	byte_mask_t l2_req_mask_o;
	logic l2_req_ack_i;
	logic l2_resp_valid_i;
	logic l2_resp_status_i;
	logic [1:0] l2_resp_unit_i;
	strand_id_t l2_resp_strand_i;
	logic l2_resp_update_i;

	// Requests as the L2 model accepted them
	strand_id_t rec_strand[$];
	pci_op_t rec_op[$];
	line_addr_t rec_addr[$];
	line_data_t rec_data[$];
	byte_mask_t rec_mask[$];

	logic ack_en;
	logic ack_taken;
	int ack_wait;
	int errors;
	int tests_run;
	int tests_failed;
	int test_err_start;

	store_path_top DUT (.*);

	always #10 clk = ~clk;

	// L2 side of the request handshake. Outputs are read before the edge updates them
	initial
	begin
		ack_wait = 0;
		ack_taken = 1'b0;
		forever
		begin
			@(posedge clk);
			if (ack_taken)
			begin
				assert (!l2_req_valid_o)
				else
				begin
					$display("Request valid did not drop in the cycle after the ack");
					errors++;
				end
			end
			ack_taken = l2_req_valid_o && l2_req_ack_i;
			if (l2_req_ack_i || !ack_en || !l2_req_valid_o)
				l2_req_ack_i <= 1'b0;
			else if (ack_wait > 0)
				ack_wait--;
			else
			begin
				l2_req_ack_i <= 1'b1;
				rec_strand.push_back(l2_req_strand_o);
				rec_op.push_back(l2_req_op_o);
				rec_addr.push_back(l2_req_addr_o);
				rec_data.push_back(l2_req_data_o);
				rec_mask.push_back(l2_req_mask_o);
				ack_wait = $urandom % 4;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the tests finished");
		$display("sim failed");
		$finish;
	end

	task automatic check(input string name, input logic [511:0] got, input logic [511:0] exp);
		assert (got === exp)
		else
		begin
			$display("Error: %s got %0h expected %0h", name, got, exp);
			errors++;
		end
	endtask

	task automatic start_test();
		test_err_start = errors;
		tests_run++;
		rec_strand.delete();
		rec_op.delete();
		rec_addr.delete();
		rec_data.delete();
		rec_mask.delete();
	endtask

	task automatic end_test(input string name);
		if (errors == test_err_start)
			$display("Test %s: ok", name);
		else
		begin
			$display("Test %s: FAILED", name);
			tests_failed++;
		end
	endtask

	function automatic line_data_t random_line();
		line_data_t l;
		for (int i = 0; i < 16; i++)
			l[i*32 +: 32] = $urandom;
		return l;
	endfunction

	// One store or load cycle, then the registered outputs a cycle later
	task automatic access(input logic w, input logic s, input strand_id_t st, input l1_tag_t tg,
		input l1_set_t se, input line_data_t d, input byte_mask_t m,
		output logic rb, output line_data_t fd, output byte_mask_t fm);
		@(posedge clk);
		write_i <= w;
		synchronized_i <= s;
		strand_i <= st;
		tag_i <= tg;
		set_i <= se;
		data_i <= d;
		mask_i <= m;
		@(posedge clk);
		write_i <= 1'b0;
		synchronized_i <= 1'b0;
		@(posedge clk);
		rb = rollback_o;
		fd = data_o;
		fm = mask_o;
	endtask

	task automatic wait_req(input int n);
		while (rec_strand.size() < n)
			@(posedge clk);
		@(posedge clk);
	endtask

	task automatic respond(input logic [1:0] unit, input strand_id_t st, input logic status,
		input logic upd, output logic upd_seen, output l1_set_t upd_set,
		output strand_mask_t resume);
		int delay;
		delay = $urandom % 4;
		repeat (delay) @(posedge clk);
		@(posedge clk);
		l2_resp_valid_i <= 1'b1;
		l2_resp_unit_i <= unit;
		l2_resp_strand_i <= st;
		l2_resp_status_i <= status;
		l2_resp_update_i <= upd;
		@(posedge clk);
		upd_seen = store_update_o;
		upd_set = store_update_set_o;
		l2_resp_valid_i <= 1'b0;
		@(posedge clk);
		resume = resume_strands_o;
	endtask

	initial
	begin : main
		line_data_t d;
		line_data_t fd;
		byte_mask_t fm;
		logic rb;
		logic us;
		l1_set_t uset;
		strand_mask_t res;
		strand_mask_t seen;

		void'($urandom(32'h1b5e_5ba3));
		clk = 1'b0;
		rst_n_i = 1'b0;
		write_i = 1'b0;
		synchronized_i = 1'b0;
		strand_i = '0;
		tag_i = '0;
		set_i = '0;
		data_i = '0;
		mask_i = '0;
		l2_req_ack_i = 1'b0;
		l2_resp_valid_i = 1'b0;
		l2_resp_status_i = 1'b0;
		l2_resp_unit_i = '0;
		l2_resp_strand_i = '0;
		l2_resp_update_i = 1'b0;
		ack_en = 1'b1;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (5) @(posedge clk);
		rst_n_i <= 1'b1;
		@(posedge clk);
		check("l2_req_valid_o", l2_req_valid_o, 0);
		check("rollback_o", rollback_o, 0);
		check("resume_strands_o", resume_strands_o, 0);
		check("store_update_o", store_update_o, 0);

		// Plain store reaches the L2 port unchanged
		start_test();
		d = random_line();
		access(1, 0, 2'd1, 20'habcde, 6'h13, d, 64'h00ff_0f0f_1234_8001, rb, fd, fm);
		wait_req(1);
		check("l2_req_op_o", rec_op[0], `PCI_STORE);
		check("l2_req_strand_o", rec_strand[0], 1);
		check("l2_req_addr_o", rec_addr[0], {20'habcde, 6'h13});
		check("l2_req_data_o", rec_data[0], d);
		check("l2_req_mask_o", rec_mask[0], 64'h00ff_0f0f_1234_8001);
		respond(`STBUF_UNIT, 2'd1, 1'b0, 1'b1, us, uset, res);
		end_test("plain store issue");

		// Forwarding only to the same strand and line
		start_test();
		d = random_line();
		access(1, 0, 2'd2, 20'h11111, 6'h05, d, 64'hf0f0_0000_ffff_0001, rb, fd, fm);
		access(0, 0, 2'd2, 20'h11111, 6'h05, '0, '0, rb, fd, fm);
		check("mask_o", fm, 64'hf0f0_0000_ffff_0001);
		check("data_o", fd, d);
		access(0, 0, 2'd3, 20'h11111, 6'h05, '0, '0, rb, fd, fm);
		check("mask_o", fm, 0);
		access(0, 0, 2'd2, 20'h11111, 6'h06, '0, '0, rb, fd, fm);
		check("mask_o", fm, 0);
		wait_req(1);
		respond(`STBUF_UNIT, 2'd2, 1'b0, 1'b1, us, uset, res);
		access(0, 0, 2'd2, 20'h11111, 6'h05, '0, '0, rb, fd, fm);
		check("mask_o", fm, 0);
		end_test("forwarding");

		// Full entry rolls back and the strand resumes after the response
		start_test();
		access(1, 0, 2'd1, 20'h22222, 6'h01, random_line(), '1, rb, fd, fm);
		check("rollback_o", rb, 0);
		d = random_line();
		access(1, 0, 2'd1, 20'h33333, 6'h02, d, 64'h5, rb, fd, fm);
		check("rollback_o", rb, 1);
		wait_req(1);
		respond(`STBUF_UNIT, 2'd1, 1'b0, 1'b1, us, uset, res);
		check("resume_strands_o", res, 4'b0010);
		access(1, 0, 2'd1, 20'h33333, 6'h02, d, 64'h5, rb, fd, fm);
		check("rollback_o", rb, 0);
		wait_req(2);
		check("l2_req_addr_o", rec_addr[1], {20'h33333, 6'h02});
		check("l2_req_data_o", rec_data[1], d);
		respond(`STBUF_UNIT, 2'd1, 1'b0, 1'b1, us, uset, res);
		end_test("buffer full");

		// Synchronized store: roll back, retry for the status, roll back again
		start_test();
		access(1, 1, 2'd0, 20'h44444, 6'h0a, random_line(), '1, rb, fd, fm);
		check("rollback_o", rb, 1);
		wait_req(1);
		check("l2_req_op_o", rec_op[0], `PCI_STORE_SYNC);
		respond(`STBUF_UNIT, 2'd0, 1'b1, 1'b0, us, uset, res);
		check("resume_strands_o", res, 4'b0001);
		access(1, 1, 2'd0, 20'h44444, 6'h0a, random_line(), '1, rb, fd, fm);
		check("rollback_o", rb, 0);
		check("mask_o", fm, 64'hffff_ffff_ffff_ffff);
		check("data_o", fd, {16{32'h1}});
		access(1, 1, 2'd0, 20'h44444, 6'h0a, random_line(), '1, rb, fd, fm);
		check("rollback_o", rb, 1);
		wait_req(2);
		respond(`STBUF_UNIT, 2'd0, 1'b0, 1'b0, us, uset, res);
		end_test("synchronized store");

		// Round-robin service under back-pressure
		start_test();
		ack_en = 1'b0;
		for (int s = 0; s < 4; s++)
			access(1, 0, strand_id_t'(s), 20'h55550 + s, 6'(s), random_line(), '1, rb, fd, fm);
		repeat (5)
		begin
			@(posedge clk);
			check("l2_req_valid_o", l2_req_valid_o, 1);
			check("l2_req_strand_o", l2_req_strand_o, 0);
		end
		ack_en = 1'b1;
		wait_req(4);
		seen = '0;
		for (int i = 0; i < 4; i++)
			seen[rec_strand[i]] = 1'b1;
		check("l2_req_strand_o set", seen, 4'hf);
		for (int i = 0; i < 4; i++)
			respond(`STBUF_UNIT, rec_strand[i], 1'b0, 1'b1, us, uset, res);
		end_test("round robin");

		// L1 update only for store-path responses with update set
		start_test();
		access(1, 0, 2'd3, 20'h66666, 6'h2a, random_line(), '1, rb, fd, fm);
		wait_req(1);
		respond(`STBUF_UNIT, 2'd3, 1'b0, 1'b1, us, uset, res);
		check("store_update_o", us, 1);
		check("store_update_set_o", uset, 6'h2a);
		access(1, 0, 2'd3, 20'h66666, 6'h15, random_line(), '1, rb, fd, fm);
		wait_req(2);
		respond(`STBUF_UNIT, 2'd3, 1'b0, 1'b0, us, uset, res);
		check("store_update_o", us, 0);
		access(1, 0, 2'd3, 20'h77777, 6'h15, random_line(), 64'h9, rb, fd, fm);
		wait_req(3);
		// Strand 3 now waits on its full entry, so a foreign response must not release it
		access(1, 0, 2'd3, 20'h88888, 6'h15, random_line(), '1, rb, fd, fm);
		check("rollback_o", rb, 1);
		respond(2'd1, 2'd3, 1'b0, 1'b1, us, uset, res);
		check("store_update_o", us, 0);
		check("resume_strands_o", res, 0);
		access(0, 0, 2'd3, 20'h77777, 6'h15, '0, '0, rb, fd, fm);
		check("mask_o", fm, 64'h9);
		respond(`STBUF_UNIT, 2'd3, 1'b0, 1'b1, us, uset, res);
		check("resume_strands_o", res, 4'b1000);
		end_test("store update");

		$display("Tests run %0d, tests failed %0d, checks failed %0d",
			tests_run, tests_failed, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+design
design/l2_pkg.sv
design/rr_arbiter.sv
design/sync_store_tracker.sv
design/store_buffer.sv
design/store_path_top.sv
testbench/tb_store_path.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_store_path
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
